//--- vcap_pkg.sv
package vcap_pkg;

  // ----------------------------------------
  // video sample and pixel formats
  // ----------------------------------------
  typedef logic [7:0]  byte_t;    // one luma or chroma sample
  typedef logic [15:0] rgb565_t;  // r[15:11] g[10:5] b[4:0]

  // byte position inside one 4:2:2 group, Cb Y0 Cr Y1 on the wire
  typedef enum logic [1:0]
  {
    PH_CB,
    PH_Y0,
    PH_CR,
    PH_Y1
  } cap_phase_e;

  // ----------------------------------------
  // frame buffer geometry
  // ----------------------------------------
  localparam int FB_IDX_W = 13;               // 8192 words per bank

  typedef logic [FB_IDX_W-1:0] fb_idx_t;      // word within a bank
  typedef logic [FB_IDX_W:0]   fb_addr_t;     // msb picks the bank

  // ----------------------------------------
  // colour conversion constants
  // ----------------------------------------
  // u2.8 fixed point, BT.601 studio range
  localparam logic [9:0] K_Y   = 10'd298;     // 1.164
  localparam logic [9:0] K_RCR = 10'd409;     // 1.596
  localparam logic [9:0] K_GCR = 10'd208;     // 0.813
  localparam logic [9:0] K_GCB = 10'd100;     // 0.392
  localparam logic [9:0] K_BCB = 10'd516;     // 2.017

  // black level and chroma zero
  localparam byte_t Y_OFFSET = 8'd16;
  localparam byte_t C_OFFSET = 8'd128;

  // products and channel sums, wide enough for 8.8 results with sign
  typedef logic signed [20:0] prod_t;

endpackage

//--- cap_if.sv
`timescale 1ns/10ps

// decimated byte stream, decimator to colour converter
interface cap_if import vcap_pkg::*;
();

  logic       byte_valid;  // one strobe per sample on a kept line
  byte_t      data;        // registered vpo
  cap_phase_e phase;       // where this byte sits in its group
  logic       keep;        // group chosen by pixel decimation

  // decimator side
  modport dec
  (
    output byte_valid,
    output data,
    output phase,
    output keep
  );

  // converter side
  modport cnv
  (
    input  byte_valid,
    input  data,
    input  phase,
    input  keep
  );

endinterface

//--- sync_decimator.sv
`timescale 1ns/10ps

module sync_decimator import vcap_pkg::*;
#(
  parameter int LINE_DECIM = 4,  // keep 1 line in LINE_DECIM
  parameter int PIX_DECIM  = 4   // keep 1 group in PIX_DECIM
)
(
  input  logic  clk_llc,
  input  logic  resetx,
  input  byte_t vpo,
  input  logic  href,
  input  logic  vref,
  input  logic  odd,
  output logic  field_active,
  cap_if.dec    cap
);

  localparam int LW = (LINE_DECIM > 1) ? $clog2(LINE_DECIM) : 1;
  localparam int PW = (PIX_DECIM > 1) ? $clog2(PIX_DECIM) : 1;

  byte_t         vpo_q;
  logic          href_q;
  logic          field_q;
  logic          field_in;
  logic          href_rise;
  logic          line_act;
  logic [LW-1:0] line_cnt;
  logic [PW-1:0] grp_cnt;
  cap_phase_e    phase;

  assign field_in  = odd & vref;     // odd field only
  assign href_rise = href & ~href_q; // raw href against its own register

  // ----------------------------------------
  // input registers
  // ----------------------------------------
  always_ff @(posedge clk_llc)
    vpo_q <= vpo;

  always_ff @(posedge clk_llc or negedge resetx)
  begin
    if (!resetx)
    begin
      href_q  <= 1'b0;
      field_q <= 1'b0;
    end
    else
    begin
      href_q  <= href;
      field_q <= field_in;
    end
  end

  // line decimation
  // parked at the top count outside a field, so the first href lands on 0
  always_ff @(posedge clk_llc or negedge resetx)
  begin
    if (!resetx)
      line_cnt <= LW'(LINE_DECIM - 1);
    else if (!field_in)
      line_cnt <= LW'(LINE_DECIM - 1);
    else if (href_rise)
      line_cnt <= (line_cnt == LW'(LINE_DECIM - 1)) ? '0 : line_cnt + 1'b1;
  end

  assign line_act = field_q & href_q & (line_cnt == '0); // every byte of a kept line

  // ----------------------------------------
  // byte phase and group decimation
  // ----------------------------------------
  always_ff @(posedge clk_llc or negedge resetx)
  begin
    if (!resetx)
    begin
      phase   <= PH_CB;
      grp_cnt <= '0;
    end
    else if (!line_act)
    begin
      phase   <= PH_CB;  // every line opens on Cb
      grp_cnt <= '0;
    end
    else
    begin
      phase <= cap_phase_e'(phase + 2'd1);
      if (phase == PH_Y1)  // last byte of the group
        grp_cnt <= (grp_cnt == PW'(PIX_DECIM - 1)) ? '0 : grp_cnt + 1'b1;
    end
  end

  assign cap.byte_valid = line_act;
  assign cap.data       = vpo_q;
  assign cap.phase      = phase;
  assign cap.keep       = (grp_cnt == '0);  // first group of each count
  assign field_active   = field_q;

endmodule

//--- ycbcr_to_rgb565.sv
`timescale 1ns/10ps

module ycbcr_to_rgb565 import vcap_pkg::*;
(
  input  logic    clk_llc,
  input  logic    resetx,
  cap_if.cnv      cap,
  output logic    pix_valid,
  output rgb565_t pixel
);

  byte_t      cb_r;
  byte_t      y0_r;
  logic       cr_hit;
  prod_t      y_s;
  prod_t      cb_s;
  prod_t      cr_s;
  prod_t      x_p;
  prod_t      rcr_p;
  prod_t      gcr_p;
  prod_t      gcb_p;
  prod_t      bcb_p;
  logic       p_valid;
  prod_t      r_sum;
  prod_t      g_sum;
  prod_t      b_sum;
  logic [5:0] r_sat;
  logic [5:0] g_sat;
  logic [5:0] b_sat;

  // saturate an 8.8 sum to a 6 bit channel
  // 5 bit channels take the upper five of these
  function automatic logic [5:0] clamp_ch(input prod_t s);
    if (s[20])
      return 6'h00;               // below black
    else if (s >= prod_t'(65536))
      return 6'h3f;               // above full scale
    else
      return s[15:10];
  endfunction

  // ----------------------------------------
  // sample capture, kept groups only
  // ----------------------------------------
  always_ff @(posedge clk_llc)
  begin
    if (cap.byte_valid && cap.keep)
    begin
      case (cap.phase)
        PH_CB:   cb_r <= cap.data;
        PH_Y0:   y0_r <= cap.data;
        default: ;                // Cr used live, Y1 dropped
      endcase
    end
  end

  assign cr_hit = cap.byte_valid & cap.keep & (cap.phase == PH_CR);

  // remove offsets, signed from here on
  assign y_s  = prod_t'(y0_r) - prod_t'(Y_OFFSET);
  assign cb_s = prod_t'(cb_r) - prod_t'(C_OFFSET);
  assign cr_s = prod_t'(cap.data) - prod_t'(C_OFFSET);  // Cr byte is on the bus now

  // ----------------------------------------
  // stage 1, products
  // ----------------------------------------
  always_ff @(posedge clk_llc)
  begin
    if (cr_hit)
    begin
      x_p   <= prod_t'(K_Y) * y_s;
      rcr_p <= prod_t'(K_RCR) * cr_s;
      gcr_p <= prod_t'(K_GCR) * cr_s;
      gcb_p <= prod_t'(K_GCB) * cb_s;
      bcb_p <= prod_t'(K_BCB) * cb_s;
    end
  end

  always_ff @(posedge clk_llc or negedge resetx)
  begin
    if (!resetx)
    begin
      p_valid   <= 1'b0;
      pix_valid <= 1'b0;
    end
    else
    begin
      p_valid   <= cr_hit;
      pix_valid <= p_valid;
    end
  end

  // stage 2, channel sums and saturation
  assign r_sum = x_p + rcr_p;
  assign g_sum = x_p - gcr_p - gcb_p;
  assign b_sum = x_p + bcb_p;

  assign r_sat = clamp_ch(r_sum);
  assign g_sat = clamp_ch(g_sum);
  assign b_sat = clamp_ch(b_sum);

  always_ff @(posedge clk_llc)
  begin
    if (p_valid)
      pixel <= {r_sat[5:1], g_sat, b_sat[5:1]};  // pack 565
  end

endmodule

//--- frame_writer.sv
`timescale 1ns/10ps

module frame_writer import vcap_pkg::*;
(
  input  logic     clk_llc,
  input  logic     resetx,
  input  logic     field_active,
  input  logic     pix_valid,
  input  rgb565_t  pixel,
  output logic     wr_en,
  output fb_addr_t wr_addr,
  output rgb565_t  wr_data,
  output logic     irq_bank0,
  output logic     irq_bank1
);

  logic    field_d;
  logic    field_rise;
  logic    field_fall;
  logic    bank;       // bank being filled
  logic    full;       // index wrapped, bank is full
  fb_idx_t idx;

  assign field_rise = field_active & ~field_d;
  assign field_fall = ~field_active & field_d;  // end of field

  // ----------------------------------------
  // index, bank and interrupts
  // ----------------------------------------
  always_ff @(posedge clk_llc or negedge resetx)
  begin
    if (!resetx)
    begin
      field_d   <= 1'b0;
      bank      <= 1'b0;
      full      <= 1'b0;
      idx       <= '0;
      wr_en     <= 1'b0;
      irq_bank0 <= 1'b0;
      irq_bank1 <= 1'b0;
    end
    else
    begin
      field_d   <= field_active;
      wr_en     <= pix_valid & ~full;   // overflow writes dropped
      irq_bank0 <= field_fall & ~bank;  // bank just filled
      irq_bank1 <= field_fall & bank;
      if (field_fall)
        bank <= ~bank;                  // swap for the next field
      if (field_rise)
      begin
        idx  <= '0;
        full <= 1'b0;
      end
      else if (pix_valid && !full)
      begin
        idx <= idx + 1'b1;
        if (idx == '1)
          full <= 1'b1;
      end
    end
  end

  // write payload, one cycle behind pix_valid
  always_ff @(posedge clk_llc)
  begin
    if (pix_valid)
    begin
      wr_addr <= {bank, idx};
      wr_data <= pixel;
    end
  end

endmodule

//--- frame_buffer.sv
`timescale 1ns/10ps

module frame_buffer import vcap_pkg::*;
(
  input  logic     clk_llc,
  input  logic     wr_en,
  input  fb_addr_t wr_addr,
  input  rgb565_t  wr_data,
  input  logic     host_rd,
  input  fb_addr_t host_addr,
  output rgb565_t  host_rdata,
  output logic     host_rvalid
);

  localparam int DEPTH = 2 * (1 << FB_IDX_W);  // both banks in one array

  rgb565_t mem [DEPTH];

  // ----------------------------------------
  // capture write port
  // ----------------------------------------
  always_ff @(posedge clk_llc)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // ----------------------------------------
  // host read port, one cycle latency
  // ----------------------------------------
  always_ff @(posedge clk_llc)
  begin
    host_rvalid <= host_rd;                 // data and valid leave together
    if (host_rd)
      host_rdata <= mem[host_addr];
  end

endmodule

//--- vcap_top.sv
`timescale 1ns/10ps

module vcap_top import vcap_pkg::*;
#(
  parameter int LINE_DECIM = 4,
  parameter int PIX_DECIM  = 4
)
(
  input  logic     clk_llc,
  input  logic     resetx,
  input  byte_t    vpo,          // decoder byte stream
  input  logic     href,
  input  logic     vref,
  input  logic     odd,
  input  logic     host_rd,
  input  fb_addr_t host_addr,
  output rgb565_t  host_rdata,
  output logic     host_rvalid,
  output logic     irq_bank0,
  output logic     irq_bank1
);

  logic     field_active;
  logic     pix_valid;
  rgb565_t  pixel;
  logic     wr_en;
  fb_addr_t wr_addr;
  rgb565_t  wr_data;

  cap_if cap_bus ();

  // ----------------------------------------
  // capture path
  // ----------------------------------------
  sync_decimator #(
    .LINE_DECIM (LINE_DECIM),
    .PIX_DECIM  (PIX_DECIM)
  ) u_dec (
    .clk_llc      (clk_llc),
    .resetx       (resetx),
    .vpo          (vpo),
    .href         (href),
    .vref         (vref),
    .odd          (odd),
    .field_active (field_active),
    .cap          (cap_bus.dec)
  );

  ycbcr_to_rgb565 u_cnv (
    .clk_llc   (clk_llc),
    .resetx    (resetx),
    .cap       (cap_bus.cnv),
    .pix_valid (pix_valid),
    .pixel     (pixel)
  );

  frame_writer u_wr (
    .clk_llc      (clk_llc),
    .resetx       (resetx),
    .field_active (field_active),
    .pix_valid    (pix_valid),
    .pixel        (pixel),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .irq_bank0    (irq_bank0),
    .irq_bank1    (irq_bank1)
  );

  // storage and host side
  frame_buffer u_fb (
    .clk_llc     (clk_llc),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .host_rd     (host_rd),
    .host_addr   (host_addr),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid)
  );

endmodule

//--- vcap_chk.sv
`timescale 1ns/10ps

module vcap_chk
(
  input logic clk_llc,
  input logic resetx,
  input logic host_rd,
  input logic host_rvalid,
  input logic irq_bank0,
  input logic irq_bank1
);

  int fail_cnt = 0;  // count of failed assertions

  // ----------------------------------------
  // field end interrupts
  // ----------------------------------------
  a_irq_excl: assert property (@(posedge clk_llc) disable iff (!resetx)
    !(irq_bank0 && irq_bank1))
    else
    begin
      fail_cnt++;
      $error("irq_bank0 and irq_bank1 high together");
    end

  a_irq0_pulse: assert property (@(posedge clk_llc) disable iff (!resetx)
    irq_bank0 |=> !irq_bank0)
    else
    begin
      fail_cnt++;
      $error("irq_bank0 longer than one cycle");
    end

  a_irq1_pulse: assert property (@(posedge clk_llc) disable iff (!resetx)
    irq_bank1 |=> !irq_bank1)
    else
    begin
      fail_cnt++;
      $error("irq_bank1 longer than one cycle");
    end

  // host read port with fixed one cycle latency
  a_rvalid: assert property (@(posedge clk_llc) disable iff (!resetx)
    host_rvalid == $past(host_rd))
    else
    begin
      fail_cnt++;
      $error("host_rvalid does not follow host_rd by one cycle");
    end

endmodule

bind vcap_top vcap_chk u_chk (.*);

//--- tb_vcap.sv
`timescale 1ns/10ps

module tb_vcap import vcap_pkg::*;
();

  localparam int LINE_DECIM  = 2;   // short fields
  localparam int PIX_DECIM   = 2;
  localparam int IRQ_TIMEOUT = 40;  // cycles allowed after vref falls

  logic     clk_llc;
  logic     resetx;
  byte_t    vpo;
  logic     href;
  logic     vref;
  logic     odd;
  logic     host_rd;
  fb_addr_t host_addr;
  rgb565_t  host_rdata;
  logic     host_rvalid;
  logic     irq_bank0;
  logic     irq_bank1;

  string   test_name;
  rgb565_t exp_q[$];    // model of the field just driven
  rgb565_t bank0_q[$];  // model contents per bank
  rgb565_t bank1_q[$];
  rgb565_t rd_q[$];     // words from the last host burst

  vcap_top #(
    .LINE_DECIM (LINE_DECIM),
    .PIX_DECIM  (PIX_DECIM)
  ) u_dut (.*);

  initial
  begin
    clk_llc = 1'b0;
    forever #10 clk_llc = ~clk_llc;  // 50 MHz
  end

  // ----------------------------------------
  // reporting and compare tasks
  // ----------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pixel(input string what, input rgb565_t exp, input rgb565_t act);
    if (act !== exp)
      abort_run($sformatf("** Error %s, %s: expected %h actual %h", test_name, what, exp, act));
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("** Error %s, %s: expected %b actual %b", test_name, what, exp, act));
  endtask

  always @(negedge clk_llc)
  begin
    if (u_dut.u_chk.fail_cnt != 0)
      abort_run("a concurrent assertion on the DUT ports failed");
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // 8.8 channel sum down to a field of the given width
  function automatic int chan(input int s, input int bits);
    if (s < 0)
      return 0;                 // clamp at black
    else if (s >= 65536)
      return (1 << bits) - 1;   // clamp at full scale
    else
      return s >> (16 - bits);  // top bits of the 16 bit sum
  endfunction

  function automatic rgb565_t to_rgb565(input int y, input int cb, input int cr);
    int x;
    int r;
    int g;
    int b;
    x = 298 * (y - 16);
    r = x + 409 * (cr - 128);
    g = x - 208 * (cr - 128) - 100 * (cb - 128);
    b = x + 516 * (cb - 128);
    return {5'(chan(r, 5)), 6'(chan(g, 6)), 5'(chan(b, 5))};
  endfunction

  // {cb, y0, cr, y1} of group k where k counts every group of the field
  function automatic logic [31:0] group_bytes(input int mode, input int line, input int k);
    logic [23:0] c;  // y cb cr
    if (mode == 0)
    begin
      case ((k >> 1) % 8)
        0:       c = {8'd16, 8'd128, 8'd128};   // black
        1:       c = {8'd235, 8'd128, 8'd128};  // white just below clamp
        2:       c = {8'd255, 8'd240, 8'd240};  // saturates high
        3:       c = {8'd16, 8'd16, 8'd16};     // red and blue go negative
        4:       c = {8'd0, 8'd128, 8'd128};    // luma under black
        5:       c = {8'd81, 8'd90, 8'd240};
        6:       c = {8'd145, 8'd54, 8'd34};
        default: c = {8'd41, 8'd240, 8'd110};
      endcase
      return {c[15:8], c[23:16], c[7:0], c[23:16] + 8'd1};
    end
    else if (mode == 1)
      return {8'd128, 8'(16 + 6 * k), 8'(128 + line), 8'd99};  // distinct per group
    else
      return $urandom();
  endfunction

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic drive_field(input logic odd_f, input int lines, input int groups,
                             input int mode);
    logic [31:0] g;
    int          k;
    exp_q.delete();
    @(posedge clk_llc);
    vref <= 1'b1;
    odd  <= odd_f;
    repeat (3) @(posedge clk_llc);  // vertical blanking
    for (int l = 0; l < lines; l++)
    begin
      for (int j = 0; j < groups; j++)
      begin
        k = l * groups + j;
        g = group_bytes(mode, l, k);
        if (odd_f && (l % LINE_DECIM == 0) && (j % PIX_DECIM == 0))
          exp_q.push_back(to_rgb565(g[23:16], g[31:24], g[15:8]));  // y0 cb cr
        for (int b = 3; b >= 0; b--)
        begin
          @(posedge clk_llc);
          href <= 1'b1;
          vpo  <= g[8*b +: 8];  // Cb first
        end
      end
      @(posedge clk_llc);
      href <= 1'b0;
      vpo  <= 8'h10;            // blanking level
      repeat (3) @(posedge clk_llc);
    end
    repeat (4) @(posedge clk_llc);  // last pixel drains into the buffer
    vref <= 1'b0;
    odd  <= 1'b0;
  endtask

  task automatic wait_irq(input logic bank);
    int cyc;
    cyc = 0;
    @(negedge clk_llc);
    while (!irq_bank0 && !irq_bank1 && cyc < IRQ_TIMEOUT)
    begin
      @(negedge clk_llc);
      cyc++;
    end
    if (!irq_bank0 && !irq_bank1)
      abort_run("no interrupt within the timeout after the end of the field");
    else
    begin
      check_bit("irq_bank0", !bank, irq_bank0);
      check_bit("irq_bank1", bank, irq_bank1);
      @(negedge clk_llc);
      check_bit("irq_bank0 width", 1'b0, irq_bank0);  // single cycle pulse
      check_bit("irq_bank1 width", 1'b0, irq_bank1);
    end
  endtask

  task automatic expect_no_irq();
    for (int cyc = 0; cyc < IRQ_TIMEOUT; cyc++)
    begin
      @(negedge clk_llc);
      if (irq_bank0 || irq_bank1)
        abort_run("an interrupt was raised for an even field");
    end
  endtask

  // back-to-back host reads with rvalid checked on every cycle
  task automatic read_bank(input logic bank, input int first, input int n);
    rd_q.delete();
    for (int i = 0; i <= n + 1; i++)
    begin
      @(posedge clk_llc);
      host_rd   <= (i < n);
      host_addr <= {bank, fb_idx_t'(first + i)};
      @(negedge clk_llc);
      check_bit("host_rvalid", (i > 0) && (i <= n), host_rvalid);
      if (host_rvalid)
        rd_q.push_back(host_rdata);
    end
  endtask

  task automatic compare_bank(input logic bank, input int first, input rgb565_t exp[$]);
    read_bank(bank, first, exp.size() - first);
    for (int i = first; i < exp.size(); i++)
      check_pixel($sformatf("bank %0d word %0d", bank, i), exp[i], rd_q[i - first]);
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  initial
  begin
    void'($urandom(14));
    resetx    = 1'b0;
    vpo       = 8'h10;
    href      = 1'b0;
    vref      = 1'b0;
    odd       = 1'b0;
    host_rd   = 1'b0;
    host_addr = '0;
    test_name = "reset";
    repeat (5) @(posedge clk_llc);
    resetx <= 1'b1;
    @(negedge clk_llc);
    check_bit("irq_bank0", 1'b0, irq_bank0);
    check_bit("irq_bank1", 1'b0, irq_bank1);
    check_bit("host_rvalid", 1'b0, host_rvalid);

    test_name = "colour conversion";
    drive_field(1'b1, 6, 5, 0);
    wait_irq(1'b0);
    bank0_q = exp_q;
    compare_bank(1'b0, 0, bank0_q);

    test_name = "decimation";
    drive_field(1'b1, 6, 6, 1);
    wait_irq(1'b1);
    bank1_q = exp_q;
    compare_bank(1'b1, 0, bank1_q);

    test_name = "ping-pong";
    drive_field(1'b1, 4, 8, 2);
    wait_irq(1'b0);
    bank0_q = exp_q;
    drive_field(1'b1, 4, 6, 2);
    wait_irq(1'b1);
    bank1_q = exp_q;
    compare_bank(1'b0, 0, bank0_q);  // first field survives the second
    compare_bank(1'b1, 0, bank1_q);

    test_name = "even field";
    drive_field(1'b0, 4, 8, 2);
    expect_no_irq();
    compare_bank(1'b0, 0, bank0_q);
    compare_bank(1'b1, 0, bank1_q);

    test_name = "read latency";
    compare_bank(1'b0, 3, bank0_q);  // burst from mid bank
    compare_bank(1'b1, 1, bank1_q);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- sim.f
vcap_pkg.sv
cap_if.sv
sync_decimator.sv
ycbcr_to_rgb565.sv
frame_writer.sv
frame_buffer.sv
vcap_top.sv
vcap_chk.sv
tb_vcap.sv

//--- Bender.yml
package:
  name: vcap

sources:
  # capture front end, compile order
  - files:
      - vcap_pkg.sv
      - cap_if.sv
      - sync_decimator.sv
      - ycbcr_to_rgb565.sv
      - frame_writer.sv
      - frame_buffer.sv
      - vcap_top.sv
  # verification only
  - target: test
    files:
      - vcap_chk.sv
      - tb_vcap.sv
